/* cnn_pkg.sv */
/*
 * Shared widths, lane counts and tap ranges of the CNN weight-fetch path,
 * along with the load packet layout and the sequencer states
 */
package cnn_pkg;

    // Lane count and convolution geometry
    localparam int LANES     = 16;
    localparam int LANES1    = 6;
    localparam int TAPS1     = 25;
    localparam int TAPS2     = 26;
    localparam int TAP2_BASE = 25;

    localparam int W_BITS    = 8;
    localparam int ADDR_BITS = 6;
    localparam int ACC_BITS  = 21;
    localparam int DEPTH     = 1 << ADDR_BITS;

    typedef logic [W_BITS-1:0]    weight_t;
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [3:0]           lane_t;
    typedef logic [ACC_BITS-1:0]  acc_t;
    typedef logic [LANES-1:0]     lane_mask_t;

    // One load word, 19 bits
    typedef struct packed {
        logic    is_act;
        lane_t   lane;
        addr_t   addr;
        weight_t data;
    } load_pkt_t;

    typedef acc_t [LANES-1:0] result_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_CONV1,
        WB_CONV2
    } wb_state_e;

endpackage

/* operand_loader.sv */
/*
 * Operand loader: accepts load packets while no pass is running and turns
 * each one into a registered write strobe for the operand memories
 */
`timescale 1ns/1ns

module operand_loader
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ld_valid_i,
    input  load_pkt_t  ld_pkt_i,
    input  logic       idle_i,
    output logic       ld_ready_o,
    output lane_mask_t wr_lane_o,
    output logic       wr_act_o,
    output addr_t      wr_addr_o,
    output weight_t    wr_data_o
);

    logic ld_fire;

    // Memories stay frozen while the sequencer reads them
    assign ld_ready_o = idle_i;
    assign ld_fire    = ld_valid_i && ld_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_lane_o <= '0;
            wr_act_o  <= 1'b0;
        end else if (ld_fire) begin
            wr_lane_o <= ld_pkt_i.is_act ? '0 : lane_mask_t'(1) << ld_pkt_i.lane;
            wr_act_o  <= ld_pkt_i.is_act;
        end else begin
            wr_lane_o <= '0;
            wr_act_o  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_fire) begin
            wr_addr_o <= ld_pkt_i.addr;
            wr_data_o <= ld_pkt_i.data;
        end
    end

endmodule

/* operand_bank.sv */
/*
 * Operand bank: sixteen weight memories and one activation memory, all read
 * at one shared address with a single cycle of read latency
 */
`timescale 1ns/1ns

module operand_bank
    import cnn_pkg::*;
(
    input  logic                 clk,
    input  lane_mask_t           wr_lane_i,
    input  logic                 wr_act_i,
    input  addr_t                wr_addr_i,
    input  weight_t              wr_data_i,
    input  lane_mask_t           rd_en_i,
    input  addr_t                rd_addr_i,
    output weight_t [LANES-1:0]  rd_data_o,
    output weight_t              act_o
);

    weight_t act_mem [DEPTH];

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        weight_t w_mem [DEPTH];

        always_ff @(posedge clk) begin
            if (wr_lane_i[i]) begin
                w_mem[wr_addr_i] <= wr_data_i;
            end
        end

        // Read register only moves when the lane is enabled
        always_ff @(posedge clk) begin
            if (rd_en_i[i]) begin
                rd_data_o[i] <= w_mem[rd_addr_i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_act_i) begin
            act_mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Activation is shared, so any enabled lane triggers a read
    always_ff @(posedge clk) begin
        if (|rd_en_i) begin
            act_o <= act_mem[rd_addr_i];
        end
    end

endmodule

/* weight_buffer.sv */
/*
 * Weight buffer sequencer: walks the shared operand address for the chosen
 * convolution and hands registered weights with per-lane valids to the PEs
 */
`timescale 1ns/1ns

module weight_buffer
    import cnn_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid_i,
    input  logic                 cmd_conv2_i,
    input  logic                 res_busy_i,
    input  weight_t [LANES-1:0]  rd_data_i,
    input  weight_t              act_i,
    output logic                 cmd_ready_o,
    output logic                 idle_o,
    output lane_mask_t           rd_en_o,
    output addr_t                rd_addr_o,
    output weight_t [LANES-1:0]  w_data_o,
    output weight_t              act_o,
    output lane_mask_t           w_valid_o,
    output logic                 first_o,
    output logic                 last_o
);

    localparam lane_mask_t CONV1_MASK = lane_mask_t'((1 << LANES1) - 1);

    wb_state_e  state_q;
    addr_t      cnt_q;
    logic       pass_q;
    logic       cmd_fire;
    logic       issue;
    lane_mask_t mask;
    addr_t      base;
    addr_t      last_tap;

    // Issue stage markers, then one stage to match the memory latency
    logic       first_iss, last_iss;
    lane_mask_t en_d;
    logic       first_d, last_d;

    // Pass flag holds from accept until the result register picks it up
    assign idle_o      = !pass_q;
    assign cmd_ready_o = (state_q == WB_IDLE) && !pass_q && !res_busy_i;
    assign cmd_fire    = cmd_valid_i && cmd_ready_o;
    assign issue       = (state_q != WB_IDLE);

    always_comb begin
        case (state_q)
            WB_CONV1: begin
                mask     = CONV1_MASK;
                base     = '0;
                last_tap = addr_t'(TAPS1 - 1);
            end
            WB_CONV2: begin
                mask     = '1;
                base     = addr_t'(TAP2_BASE);
                last_tap = addr_t'(TAPS2 - 1);
            end
            default: begin
                mask     = '0;
                base     = '0;
                last_tap = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= WB_IDLE;
            cnt_q     <= '0;
            pass_q    <= 1'b0;
            rd_en_o   <= '0;
            first_iss <= 1'b0;
            last_iss  <= 1'b0;
            en_d      <= '0;
            first_d   <= 1'b0;
            last_d    <= 1'b0;
            w_valid_o <= '0;
            first_o   <= 1'b0;
            last_o    <= 1'b0;
        end else begin
            rd_en_o   <= mask;
            first_iss <= issue && (cnt_q == '0);
            last_iss  <= issue && (cnt_q == last_tap);
            en_d      <= rd_en_o;
            first_d   <= first_iss;
            last_d    <= last_iss;
            w_valid_o <= en_d;
            first_o   <= first_d;
            last_o    <= last_d;

            if (cmd_fire) begin
                pass_q <= 1'b1;
            end else if (res_busy_i) begin
                pass_q <= 1'b0;
            end

            case (state_q)
                WB_IDLE: begin
                    if (cmd_fire) begin
                        state_q <= cmd_conv2_i ? WB_CONV2 : WB_CONV1;
                        cnt_q   <= '0;
                    end
                end
                default: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == last_tap) begin
                        state_q <= WB_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rd_addr_o <= base + cnt_q;
        end
    end

    // One clock of memory read latency already spent in the bank
    always_ff @(posedge clk) begin
        w_data_o <= rd_data_i;
        act_o    <= act_i;
    end

endmodule

/* pe_row.sv */
/*
 * Processing element row: sixteen unsigned multiply-accumulate lanes
 * sharing one activation, restarted on the first tap of every pass
 */
`timescale 1ns/1ns

module pe_row
    import cnn_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  weight_t [LANES-1:0]  w_data_i,
    input  weight_t              act_i,
    input  lane_mask_t           w_valid_i,
    input  logic                 first_i,
    input  logic                 last_i,
    output result_t              sum_o,
    output logic                 done_o
);

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic [2*W_BITS-1:0] prod;

        assign prod = w_data_i[i] * act_i;

        // Lanes idle for this pass are zeroed on the first tap
        always_ff @(posedge clk) begin
            if (first_i) begin
                sum_o[i] <= w_valid_i[i] ? acc_t'(prod) : '0;
            end else if (w_valid_i[i]) begin
                sum_o[i] <= sum_o[i] + acc_t'(prod);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_o <= 1'b0;
        end else begin
            done_o <= last_i;
        end
    end

endmodule

/* result_out.sv */
/*
 * Result register: holds the lane sums of a finished pass until the
 * consumer takes them over a valid/ready handshake
 */
`timescale 1ns/1ns

module result_out
    import cnn_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  result_t sum_i,
    input  logic    done_i,
    input  logic    res_ready_i,
    output result_t res_o,
    output logic    res_valid_o,
    output logic    busy_o
);

    assign busy_o = res_valid_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid_o <= 1'b0;
        end else if (done_i) begin
            res_valid_o <= 1'b1;
        end else if (res_valid_o && res_ready_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done_i) begin
            res_o <= sum_i;
        end
    end

endmodule

/* conv_weight_top.sv */
/*
 * Weight-fetch and multiply path: loader, operand memories, sequencer,
 * PE row and result register
 */
`timescale 1ns/1ns

module conv_weight_top
    import cnn_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ld_valid_i,
    input  load_pkt_t ld_pkt_i,
    input  logic      cmd_valid_i,
    input  logic      cmd_conv2_i,
    input  logic      res_ready_i,
    output logic      ld_ready_o,
    output logic      cmd_ready_o,
    output result_t   res_o,
    output logic      res_valid_o
);

    // Load side
    lane_mask_t wr_lane;
    logic       wr_act;
    addr_t      wr_addr;
    weight_t    wr_data;
    logic       idle;

    // Read side
    lane_mask_t          rd_en;
    addr_t               rd_addr;
    weight_t [LANES-1:0] rd_data;
    weight_t             rd_act;

    // Into the array
    weight_t [LANES-1:0] w_data;
    weight_t             w_act;
    lane_mask_t          w_valid;
    logic                first;
    logic                last;
    result_t             sum;
    logic                done;
    logic                res_busy;

    operand_loader u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .ld_valid_i (ld_valid_i),
        .ld_pkt_i   (ld_pkt_i),
        .idle_i     (idle),
        .ld_ready_o (ld_ready_o),
        .wr_lane_o  (wr_lane),
        .wr_act_o   (wr_act),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data)
    );

    operand_bank u_bank (
        .clk       (clk),
        .wr_lane_i (wr_lane),
        .wr_act_i  (wr_act),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .act_o     (rd_act)
    );

    weight_buffer u_wbuf (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_conv2_i (cmd_conv2_i),
        .res_busy_i  (res_busy),
        .rd_data_i   (rd_data),
        .act_i       (rd_act),
        .cmd_ready_o (cmd_ready_o),
        .idle_o      (idle),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .w_data_o    (w_data),
        .act_o       (w_act),
        .w_valid_o   (w_valid),
        .first_o     (first),
        .last_o      (last)
    );

    pe_row u_pe (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_data_i  (w_data),
        .act_i     (w_act),
        .w_valid_i (w_valid),
        .first_i   (first),
        .last_i    (last),
        .sum_o     (sum),
        .done_o    (done)
    );

    result_out u_res (
        .clk         (clk),
        .rst_n       (rst_n),
        .sum_i       (sum),
        .done_i      (done),
        .res_ready_i (res_ready_i),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .busy_o      (res_busy)
    );

endmodule

/* tb_conv_weight_top.sv */
/*
 * Testbench for the CNN weight-fetch path: loads random operands, runs both
 * convolutions and checks sums, latency, back-pressure and load blocking
 */
`timescale 1ns/1ns

module tb_conv_weight_top
    import cnn_pkg::*;
;

    localparam int MAX_CYCLES = 4000;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      ld_valid;
    load_pkt_t ld_pkt;
    logic      cmd_valid;
    logic      cmd_conv2;
    logic      res_ready;
    logic      ld_ready_o;
    logic      cmd_ready_o;
    result_t   res_o;
    logic      res_valid_o;

    integer  seed = 32'h6e382240;
    int      cycle_cnt = 0;
    weight_t w_mirror [LANES][DEPTH];
    weight_t a_mirror [DEPTH];

    conv_weight_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ld_valid_i  (ld_valid),
        .ld_pkt_i    (ld_pkt),
        .cmd_valid_i (cmd_valid),
        .cmd_conv2_i (cmd_conv2),
        .res_ready_i (res_ready),
        .ld_ready_o  (ld_ready_o),
        .cmd_ready_o (cmd_ready_o),
        .res_o       (res_o),
        .res_valid_o (res_valid_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic fail_now(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1) else fail_now(msg);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            fail_now($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    // Sum of weight times activation over the taps of one convolution
    function automatic int expected_sum(input logic conv2, input int lane);
        int acc;
        int base;
        int taps;
        acc  = 0;
        base = conv2 ? TAP2_BASE : 0;
        taps = conv2 ? TAPS2 : TAPS1;
        if (!conv2 && lane >= LANES1) begin
            return 0;
        end
        for (int a = base; a < base + taps; a++) begin
            acc = acc + int'(w_mirror[lane][a]) * int'(a_mirror[a]);
        end
        return acc;
    endfunction

    task automatic fill_random();
        for (int l = 0; l < LANES; l++) begin
            for (int a = 0; a < DEPTH; a++) begin
                w_mirror[l][a] = weight_t'($random(seed));
            end
        end
        for (int a = 0; a < DEPTH; a++) begin
            a_mirror[a] = weight_t'($random(seed));
        end
    endtask

    // Holds valid until a cycle with ready high has passed
    task automatic load_word(input load_pkt_t pkt);
        logic taken;
        taken    = 1'b0;
        ld_pkt   = pkt;
        ld_valid = 1'b1;
        while (!taken) begin
            taken = ld_ready_o;
            @(posedge clk);
            #1;
        end
        ld_valid = 1'b0;
    endtask

    task automatic load_all();
        load_pkt_t pkt;
        for (int l = 0; l <= LANES; l++) begin
            for (int a = 0; a < DEPTH; a++) begin
                pkt.is_act = (l == LANES);
                pkt.lane   = lane_t'(l);
                pkt.addr   = addr_t'(a);
                pkt.data   = (l == LANES) ? a_mirror[a] : w_mirror[l][a];
                load_word(pkt);
            end
        end
    endtask

    task automatic run_pass(input logic conv2, input logic poke, input int hold);
        int        cycles;
        int        taps;
        result_t   held;
        load_pkt_t bad;
        taps      = conv2 ? TAPS2 : TAPS1;
        cmd_conv2 = conv2;
        cmd_valid = 1'b1;
        while (!cmd_ready_o) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cycles    = 0;
        // Try to overwrite a lane 0 weight that the second convolution reads
        if (poke) begin
            bad.is_act = 1'b0;
            bad.lane   = '0;
            bad.addr   = addr_t'(TAP2_BASE);
            bad.data   = ~w_mirror[0][TAP2_BASE];
            ld_pkt     = bad;
            ld_valid   = 1'b1;
        end
        while (!res_valid_o) begin
            check_true(!ld_ready_o, "ld_ready_o high during a pass");
            check_true(!cmd_ready_o, "cmd_ready_o high during a pass");
            @(posedge clk);
            #1;
            cycles++;
        end
        ld_valid = 1'b0;
        check_value("result latency", cycles, taps + 4);
        check_true(!cmd_ready_o, "cmd_ready_o high with result pending");
        for (int l = 0; l < LANES; l++) begin
            check_value($sformatf("lane %0d sum", l), res_o[l], expected_sum(conv2, l));
        end
        held = res_o;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #1;
            check_true(res_valid_o, "res_valid_o dropped while stalled");
            check_true(res_o === held, "res_o changed while stalled");
            check_true(!cmd_ready_o, "cmd_ready_o high while stalled");
        end
        if (hold > 0) begin
            check_true(ld_ready_o, "ld_ready_o low while result is held");
        end
        res_ready = 1'b1;
        @(posedge clk);
        #1;
        res_ready = 1'b0;
        check_true(!res_valid_o, "res_valid_o still high after handshake");
        check_true(cmd_ready_o, "cmd_ready_o low after result taken");
    endtask

    initial begin
        rst_n     = 1'b0;
        ld_valid  = 1'b0;
        ld_pkt    = '0;
        cmd_valid = 1'b0;
        cmd_conv2 = 1'b0;
        res_ready = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_true(!res_valid_o, "res_valid_o high after reset");
        check_true(cmd_ready_o, "cmd_ready_o low after reset");
        check_true(ld_ready_o, "ld_ready_o low after reset");

        fill_random();
        load_all();
        run_pass(1'b0, 1'b1, 0);
        run_pass(1'b1, 1'b0, 5);

        // Fresh operands, then both passes back to back
        fill_random();
        load_all();
        run_pass(1'b0, 1'b0, 0);
        run_pass(1'b1, 1'b0, 0);

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* list.f */
cnn_pkg.sv
operand_loader.sv
operand_bank.sv
weight_buffer.sv
pe_row.sv
result_out.sv
conv_weight_top.sv
tb_conv_weight_top.sv

/* Bender.yml */
package:
  name: conv_weight

sources:
  - files:
      - cnn_pkg.sv
      - operand_loader.sv
      - operand_bank.sv
      - weight_buffer.sv
      - pe_row.sv
      - result_out.sv
      - conv_weight_top.sv
  - target: test
    files:
      - tb_conv_weight_top.sv
